//--- qspi_pkg.sv
package qspi_pkg;

    // ----------------------------------------
    // widths and constants
    // ----------------------------------------
    localparam int unsigned BYTE_W    = 8;
    localparam int unsigned SCK_DIV_W = 11;

    // terminal counts, half period is count + 1 clk
    localparam logic [SCK_DIV_W-1:0] SCK_DIV_TABLE [0:11] = '{
        11'd0, 11'd1, 11'd7, 11'd15, 11'd3, 11'd31,
        11'd63, 11'd127, 11'd255, 11'd511, 11'd1023, 11'd2047
    };

    localparam logic [BYTE_W-1:0] LAST_BIT_SINGLE = 8'd7;
    localparam logic [BYTE_W-1:0] LAST_BIT_DUAL   = 8'd6;
    localparam logic [BYTE_W-1:0] LAST_BIT_QUAD   = 8'd4;

    // ----------------------------------------
    // types
    // ----------------------------------------
    typedef enum logic [1:0] {
        LANES_SINGLE = 2'b00,
        LANES_DUAL   = 2'b01,
        LANES_QUAD   = 2'b10     // 2'b11 not allowed
    } qspi_lanes_e;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'b00,
        ST_DUMMY    = 2'b01,
        ST_TRANSFER = 2'b10
    } qspi_state_e;

    typedef union packed {
        logic [BYTE_W-1:0] data_byte;     // transfer
        logic [BYTE_W-1:0] dummy_count;   // dummy clocks minus one
    } qspi_payload_u;

    typedef struct packed {
        logic          read;
        logic          dummy;
        qspi_lanes_e   lanes;
        qspi_payload_u payload;
    } qspi_req_t;

    typedef struct packed {
        logic [1:0] mode;        // cpol, cpha
        logic [3:0] div;
        logic       duplex_en;
    } qspi_cfg_t;

    typedef struct packed {
        logic       sck;
        logic [3:0] dq_o;
        logic [3:0] dq_en;
    } qspi_pad_out_t;

    typedef struct packed {
        logic tick;
        logic sample;
        logic shift;
    } qspi_edge_t;

    // ----------------------------------------
    // lane helpers
    // ----------------------------------------
    function automatic logic [BYTE_W-1:0] last_bit(qspi_lanes_e lanes);
        logic [BYTE_W-1:0] last;
        case (lanes)
            LANES_DUAL: last = LAST_BIT_DUAL;
            LANES_QUAD: last = LAST_BIT_QUAD;
            default:    last = LAST_BIT_SINGLE;
        endcase
        return last;
    endfunction

    function automatic logic [BYTE_W-1:0] lane_step(qspi_lanes_e lanes);
        logic [BYTE_W-1:0] step;
        case (lanes)
            LANES_DUAL: step = 8'd2;
            LANES_QUAD: step = 8'd4;
            default:    step = 8'd1;
        endcase
        return step;
    endfunction

endpackage

//--- qspi_sck_gen.sv
`timescale 1ns/10ps

module qspi_sck_gen (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  qspi_pkg::qspi_cfg_t   i_cfg,
    input  qspi_pkg::qspi_state_e i_state,
    input  logic                  i_start,
    output qspi_pkg::qspi_edge_t  o_edge,
    output logic                  o_sck
);

    logic [qspi_pkg::SCK_DIV_W-1:0] div_term;
    logic [qspi_pkg::SCK_DIV_W-1:0] div_cnt;
    logic                           running;
    logic                           tick;
    logic                           sck_lvl;
    logic                           mode_swap;
    logic                           rising;

    // ----------------------------------------
    // divider
    // ----------------------------------------
    assign div_term = (i_cfg.div > 4'd11) ? qspi_pkg::SCK_DIV_TABLE[0]
                                          : qspi_pkg::SCK_DIV_TABLE[i_cfg.div];

    assign running = (i_state != qspi_pkg::ST_IDLE);
    assign tick    = running && (div_cnt == div_term);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
        end else if (!running || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // sck level
    // ----------------------------------------
    assign mode_swap = i_cfg.mode[1] ^ i_cfg.mode[0];   // modes 1 and 2

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            sck_lvl <= 1'b0;
        end else if (i_start) begin
            sck_lvl <= mode_swap;                        // preload first edge
        end else if (tick) begin
            sck_lvl <= ~sck_lvl;
        end
    end

    // parked at polarity between requests
    assign o_sck = running ? sck_lvl : i_cfg.mode[1];

    assign rising = ~sck_lvl;

    always_comb begin
        o_edge.tick   = tick;
        o_edge.sample = tick & (rising ^ mode_swap);
        o_edge.shift  = tick & ~(rising ^ mode_swap);
    end

    // divider and sck level need a steady mode and divider while a request runs
    assert property (@(posedge clk) disable iff (!i_rst_n)
        running |-> $stable(i_cfg.mode) && $stable(i_cfg.div));

endmodule

//--- qspi_seq.sv
`timescale 1ns/10ps

module qspi_seq (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_req_vld,
    input  qspi_pkg::qspi_req_t           i_req,
    input  qspi_pkg::qspi_edge_t          i_edge,
    input  logic                          i_rsp_pending,
    output logic                          o_req_rdy,
    output qspi_pkg::qspi_state_e         o_state,
    output logic [qspi_pkg::BYTE_W-1:0]   o_bit_cnt,
    output qspi_pkg::qspi_req_t           o_buf,
    output logic                          o_start,
    output logic                          o_busy
);

    qspi_pkg::qspi_state_e          state_q;
    qspi_pkg::qspi_state_e          state_nxt;
    qspi_pkg::qspi_req_t            buf_q;
    logic [qspi_pkg::BYTE_W-1:0]    cnt_q;
    logic [qspi_pkg::BYTE_W-1:0]    cnt_last;
    logic [qspi_pkg::BYTE_W-1:0]    cnt_step;
    logic                           rdy_q;
    logic                           accept;
    logic                           active;
    logic                           done;

    assign accept = i_req_vld && rdy_q;
    assign active = (state_q != qspi_pkg::ST_IDLE);

    // ----------------------------------------
    // request buffer
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            buf_q <= i_req;
        end
    end

    // ----------------------------------------
    // bit counter
    // ----------------------------------------
    always_comb begin
        if (state_q == qspi_pkg::ST_DUMMY) begin
            cnt_last = buf_q.payload.dummy_count;
            cnt_step = 8'd1;
        end else begin
            cnt_last = qspi_pkg::last_bit(buf_q.lanes);
            cnt_step = qspi_pkg::lane_step(buf_q.lanes);
        end
    end

    assign done = active && i_edge.shift && (cnt_q == cnt_last);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (!active || done) begin
            cnt_q <= '0;
        end else if (i_edge.shift) begin
            cnt_q <= cnt_q + cnt_step;
        end
    end

    // ----------------------------------------
    // state machine
    // ----------------------------------------
    always_comb begin
        state_nxt = state_q;
        if (state_q == qspi_pkg::ST_IDLE) begin
            if (accept) begin
                state_nxt = i_req.dummy ? qspi_pkg::ST_DUMMY : qspi_pkg::ST_TRANSFER;
            end
        end else if (done) begin
            state_nxt = qspi_pkg::ST_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= qspi_pkg::ST_IDLE;
            rdy_q   <= 1'b0;
        end else begin
            state_q <= state_nxt;
            rdy_q   <= (state_nxt == qspi_pkg::ST_IDLE) && !i_rsp_pending;  // idle, no rsp
        end
    end

    assign o_req_rdy = rdy_q;
    assign o_state   = state_q;
    assign o_bit_cnt = cnt_q;
    assign o_buf     = buf_q;
    assign o_start   = accept;
    assign o_busy    = active;

    // lane code 3 has no meaning
    assert property (@(posedge clk) disable iff (!i_rst_n)
        accept |-> (i_req.lanes != 2'd3));

    // a waiting response blocks the next request
    assert property (@(posedge clk) disable iff (!i_rst_n)
        accept |-> !i_rsp_pending);

endmodule

//--- qspi_shifter.sv
`timescale 1ns/10ps

module qspi_shifter (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  qspi_pkg::qspi_state_e         i_state,
    input  logic [qspi_pkg::BYTE_W-1:0]   i_bit_cnt,
    input  qspi_pkg::qspi_req_t           i_buf,
    input  qspi_pkg::qspi_cfg_t           i_cfg,
    input  qspi_pkg::qspi_edge_t          i_edge,
    input  logic [3:0]                    i_dq,
    input  logic                          i_rsp_rdy,
    output logic [3:0]                    o_dq_o,
    output logic [3:0]                    o_dq_en,
    output logic                          o_rsp_vld,
    output logic [qspi_pkg::BYTE_W-1:0]   o_rsp_dat,
    output logic                          o_rsp_pending
);

    logic [qspi_pkg::BYTE_W-1:0] tx_sh;
    logic [qspi_pkg::BYTE_W-1:0] rx_q;
    logic [qspi_pkg::BYTE_W-1:0] rx_nxt;
    logic                        in_xfer;
    logic                        wr;
    logic                        rx_on;
    logic                        rx_take;
    logic                        rsp_set;
    logic                        rsp_vld_q;

    assign in_xfer = (i_state == qspi_pkg::ST_TRANSFER);
    assign wr      = ~i_buf.read;

    // ----------------------------------------
    // transmit
    // ----------------------------------------
    assign tx_sh = i_buf.payload.data_byte << i_bit_cnt;   // next bits at the top

    always_comb begin
        o_dq_o  = 4'b0000;
        o_dq_en = 4'b0000;
        case (i_buf.lanes)
            qspi_pkg::LANES_DUAL: begin
                o_dq_o  = {2'b00, tx_sh[7:6]};
                o_dq_en = {2'b00, {2{in_xfer & wr}}};
            end
            qspi_pkg::LANES_QUAD: begin
                o_dq_o  = tx_sh[7:4];
                o_dq_en = {4{in_xfer & wr}};                 // released on reads
            end
            default: begin
                o_dq_o  = {3'b000, tx_sh[7]};
                o_dq_en = {3'b000, in_xfer};                 // mosi always driven
            end
        endcase
    end

    // ----------------------------------------
    // receive
    // ----------------------------------------
    always_comb begin
        case (i_buf.lanes)
            qspi_pkg::LANES_DUAL: begin
                rx_on  = i_buf.read;
                rx_nxt = {rx_q[5:0], i_dq[1:0]};
            end
            qspi_pkg::LANES_QUAD: begin
                rx_on  = i_buf.read;
                rx_nxt = {rx_q[3:0], i_dq};
            end
            default: begin
                rx_on  = i_buf.read | i_cfg.duplex_en;
                rx_nxt = {rx_q[6:0], i_dq[1]};             // miso
            end
        endcase
    end

    assign rx_take = in_xfer && i_edge.sample && rx_on;
    assign rsp_set = rx_take && (i_bit_cnt == qspi_pkg::last_bit(i_buf.lanes));

    always_ff @(posedge clk) begin
        if (rx_take) begin
            rx_q <= rx_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rsp_vld_q <= 1'b0;
        end else if (rsp_set) begin
            rsp_vld_q <= 1'b1;
        end else if (rsp_vld_q && i_rsp_rdy) begin
            rsp_vld_q <= 1'b0;
        end
    end

    assign o_rsp_vld     = rsp_vld_q;
    assign o_rsp_dat     = rx_q;
    assign o_rsp_pending = rsp_vld_q;

    // a new byte never lands on top of a waiting one
    assert property (@(posedge clk) disable iff (!i_rst_n)
        rsp_set |-> !rsp_vld_q);

    // held response keeps its data until taken
    assert property (@(posedge clk) disable iff (!i_rst_n)
        o_rsp_vld && !i_rsp_rdy |=> o_rsp_vld && $stable(o_rsp_dat));

endmodule

//--- qspi_top.sv
`timescale 1ns/10ps

module qspi_top (
    input  logic                          clk,
    input  logic                          i_rst_n,

    input  logic                          i_req_vld,
    input  qspi_pkg::qspi_req_t           i_req,
    output logic                          o_req_rdy,

    output logic                          o_rsp_vld,
    output logic [qspi_pkg::BYTE_W-1:0]   o_rsp_dat,
    input  logic                          i_rsp_rdy,

    input  qspi_pkg::qspi_cfg_t           i_cfg,

    output qspi_pkg::qspi_pad_out_t       o_pad,
    input  logic [3:0]                    i_dq,

    output logic                          o_busy
);

    qspi_pkg::qspi_edge_t          sck_edge;
    qspi_pkg::qspi_state_e         state;
    qspi_pkg::qspi_req_t           req_buf;
    logic [qspi_pkg::BYTE_W-1:0]   bit_cnt;
    logic                          start;
    logic                          sck;
    logic [3:0]                    dq_o;
    logic [3:0]                    dq_en;
    logic                          rsp_pending;

    qspi_sck_gen u_sck_gen (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_cfg     (i_cfg),
        .i_state   (state),
        .i_start   (start),
        .o_edge    (sck_edge),
        .o_sck     (sck)
    );

    qspi_seq u_seq (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_req_vld     (i_req_vld),
        .i_req         (i_req),
        .i_edge        (sck_edge),
        .i_rsp_pending (rsp_pending),
        .o_req_rdy     (o_req_rdy),
        .o_state       (state),
        .o_bit_cnt     (bit_cnt),
        .o_buf         (req_buf),
        .o_start       (start),
        .o_busy        (o_busy)
    );

    qspi_shifter u_shifter (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_state       (state),
        .i_bit_cnt     (bit_cnt),
        .i_buf         (req_buf),
        .i_cfg         (i_cfg),
        .i_edge        (sck_edge),
        .i_dq          (i_dq),
        .i_rsp_rdy     (i_rsp_rdy),
        .o_dq_o        (dq_o),
        .o_dq_en       (dq_en),
        .o_rsp_vld     (o_rsp_vld),
        .o_rsp_dat     (o_rsp_dat),
        .o_rsp_pending (rsp_pending)
    );

    assign o_pad = '{sck: sck, dq_o: dq_o, dq_en: dq_en};   // pad bundle

endmodule

//--- tb_qspi.sv
`timescale 1ns/10ps

module tb_qspi;

    localparam int HALF_DIV3 = 16;                          // clk per sck half period at div 3
    localparam int BYTE_CYC  = 8 * 2 * HALF_DIV3 + 40;
    localparam int DUMMY_CYC = 16 * 2 * HALF_DIV3 + 40;
    localparam int N_BYTES   = 12;
    localparam int CYC_LIMIT = (20 + N_BYTES * BYTE_CYC + DUMMY_CYC) * 12 / 10;

    logic                    clk = 1'b0;
    logic                    i_rst_n = 1'b0;
    logic                    i_req_vld = 1'b0;
    qspi_pkg::qspi_req_t     i_req = '0;
    logic                    o_req_rdy;
    logic                    o_rsp_vld;
    logic [7:0]              o_rsp_dat;
    logic                    i_rsp_rdy = 1'b1;
    qspi_pkg::qspi_cfg_t     i_cfg = '0;
    qspi_pkg::qspi_pad_out_t o_pad;
    logic [3:0]              i_dq = 4'h0;
    logic                    o_busy;

    logic [15:0] lfsr = 16'd23108;
    int          cyc_cnt = 0;
    int          n_err = 0;
    int          n_chk = 0;
    int          n_test = 0;
    int          n_bad = 0;

    // slave model state
    logic        arm_req = 1'b0;
    logic [7:0]  slv_reply = 8'h00;
    int          slv_w = 1;
    int          out_idx = 0;
    logic        sck_d = 1'b0;
    logic [7:0]  seen = 8'h00;
    logic [3:0]  en_seen = 4'h0;
    int          n_rise = 0;
    int          last_edge = 0;
    logic        have_edge = 1'b0;
    int          gap_min = 0;
    int          gap_max = 0;

    // response monitor
    int          rsp_cnt = 0;
    logic [7:0]  rsp_last = 8'h00;

    qspi_top dut (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_req_vld (i_req_vld),
        .i_req     (i_req),
        .o_req_rdy (o_req_rdy),
        .o_rsp_vld (o_rsp_vld),
        .o_rsp_dat (o_rsp_dat),
        .i_rsp_rdy (i_rsp_rdy),
        .i_cfg     (i_cfg),
        .o_pad     (o_pad),
        .i_dq      (i_dq),
        .o_busy    (o_busy)
    );

    always #4 clk = ~clk;

    // ----------------------------------------
    // watchdog and monitors
    // ----------------------------------------
    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= CYC_LIMIT) begin
            $display("timeout: the DUT did not finish within %0d cycles", CYC_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (o_rsp_vld && i_rsp_rdy) begin
            rsp_cnt  <= rsp_cnt + 1;
            rsp_last <= o_rsp_dat;
        end
    end

    function automatic logic [3:0] lane_chunk(input logic [7:0] b, input int idx, input int w);
        logic [7:0] sh;
        sh = b << (idx * w);
        case (w)
            2:       return {2'b00, sh[7:6]};
            4:       return sh[7:4];
            default: return {2'b00, sh[7], 1'b0};              // miso on dq1
        endcase
    endfunction

    // ----------------------------------------
    // SPI slave model
    // ----------------------------------------
    always @(posedge clk) begin
        sck_d <= o_pad.sck;
        if (arm_req) begin
            out_idx   <= i_cfg.mode[0] ? 0 : 1;
            i_dq      <= i_cfg.mode[0] ? 4'h0 : lane_chunk(slv_reply, 0, slv_w);
            seen      <= 8'h00;
            en_seen   <= 4'h0;
            n_rise    <= 0;
            have_edge <= 1'b0;
            gap_min   <= 1000;
            gap_max   <= 0;
        end else begin
            en_seen <= en_seen | o_pad.dq_en;
            if (o_pad.sck != sck_d) begin
                if (o_pad.sck) begin
                    n_rise <= n_rise + 1;
                end
                if (o_pad.sck ^ i_cfg.mode[1] ^ i_cfg.mode[0]) begin   // sample edge
                    case (slv_w)
                        2:       seen <= {seen[5:0], o_pad.dq_o[1:0]};
                        4:       seen <= {seen[3:0], o_pad.dq_o};
                        default: seen <= {seen[6:0], o_pad.dq_o[0]};
                    endcase
                end else begin
                    i_dq    <= lane_chunk(slv_reply, out_idx, slv_w);
                    out_idx <= out_idx + 1;
                end
                if (have_edge) begin
                    if (cyc_cnt - last_edge < gap_min) begin
                        gap_min <= cyc_cnt - last_edge;
                    end
                    if (cyc_cnt - last_edge > gap_max) begin
                        gap_max <= cyc_cnt - last_edge;
                    end
                end
                last_edge <= cyc_cnt;
                have_edge <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // compare tasks and helpers
    // ----------------------------------------
    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_state(input string name, input qspi_pkg::qspi_state_e got,
                               input qspi_pkg::qspi_state_e exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("error at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] v);
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic arm_slave(input logic [7:0] reply, input int w);
        @(posedge clk);
        slv_reply <= reply;
        slv_w     <= w;
        arm_req   <= 1'b1;
        @(posedge clk);
        arm_req   <= 1'b0;
        @(posedge clk);
    endtask

    task automatic send_req(input qspi_pkg::qspi_req_t r);
        @(posedge clk);
        i_req     <= r;
        i_req_vld <= 1'b1;
        do @(posedge clk); while (!o_req_rdy);
        i_req_vld <= 1'b0;
        @(posedge clk);
        check_state("dut.state", dut.state,
                    r.dummy ? qspi_pkg::ST_DUMMY : qspi_pkg::ST_TRANSFER);
        check_bit("o_busy", o_busy, 1'b1);
    endtask

    task automatic wait_idle();
        do @(posedge clk); while (o_busy);
        repeat (2) @(posedge clk);                         // slave sees the last edge
    endtask

    task automatic set_cfg(input logic [1:0] mode, input logic [3:0] div, input logic dup);
        @(posedge clk);
        i_cfg <= '{mode: mode, div: div, duplex_en: dup};
        @(posedge clk);
    endtask

    function automatic qspi_pkg::qspi_req_t make_req(input logic rd, input logic dmy,
                                                     input qspi_pkg::qspi_lanes_e lanes,
                                                     input logic [7:0] pl);
        qspi_pkg::qspi_req_t r;
        r.read              = rd;
        r.dummy             = dmy;
        r.lanes             = lanes;
        r.payload.data_byte = pl;
        return r;
    endfunction

    function automatic int lane_width(input qspi_pkg::qspi_lanes_e lanes);
        return (lanes == qspi_pkg::LANES_DUAL) ? 2 : (lanes == qspi_pkg::LANES_QUAD) ? 4 : 1;
    endfunction

    task automatic report_test(input string name, input int err_before);
        n_test++;
        if (n_err == err_before) begin
            $display("%-26s ok", name);
        end else begin
            n_bad++;
            $display("%-26s FAILED", name);
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic single_write_mode(input logic [1:0] mode);
        int         e0;
        logic [7:0] pl;
        logic [7:0] rp;
        e0 = n_err;
        draw_bits(8, pl);
        draw_bits(8, rp);
        set_cfg(mode, 4'd3, 1'b0);
        arm_slave(rp, 1);
        check_bit("o_pad.sck idle", o_pad.sck, mode[1]);
        send_req(make_req(1'b0, 1'b0, qspi_pkg::LANES_SINGLE, pl));
        wait_idle();
        check_byte("slave mosi byte", seen, pl);
        check_bit("o_pad.sck idle", o_pad.sck, mode[1]);
        check_byte("dq_en seen", {4'h0, en_seen}, 8'h01);
        check_byte("sck periods", 8'(n_rise), 8'd8);
        report_test($sformatf("single write mode %0d", mode), e0);
    endtask

    task automatic duplex_write(input logic dup);
        int         e0;
        int         r0;
        logic [7:0] pl;
        logic [7:0] rp;
        e0 = n_err;
        r0 = rsp_cnt;
        draw_bits(8, pl);
        draw_bits(8, rp);
        set_cfg(2'd0, 4'd3, dup);
        arm_slave(rp, 1);
        send_req(make_req(1'b0, 1'b0, qspi_pkg::LANES_SINGLE, pl));
        wait_idle();
        check_byte("slave mosi byte", seen, pl);
        check_byte("responses", 8'(rsp_cnt - r0), dup ? 8'd1 : 8'd0);
        if (dup) begin
            check_byte("o_rsp_dat", rsp_last, rp);
        end
        report_test($sformatf("duplex write en=%0d", dup), e0);
    endtask

    task automatic multi_read(input qspi_pkg::qspi_lanes_e lanes);
        int         e0;
        int         r0;
        int         w;
        logic [7:0] rp;
        e0 = n_err;
        r0 = rsp_cnt;
        w  = lane_width(lanes);
        draw_bits(8, rp);
        set_cfg(2'd0, 4'd3, 1'b0);
        arm_slave(rp, w);
        send_req(make_req(1'b1, 1'b0, lanes, 8'h00));
        wait_idle();
        check_byte("responses", 8'(rsp_cnt - r0), 8'd1);
        check_byte("o_rsp_dat", rsp_last, rp);
        check_byte("dq_en seen", {4'h0, en_seen}, 8'h00);
        check_byte("sck periods", 8'(n_rise), 8'(8 / w));
        report_test($sformatf("read on %0d lanes", w), e0);
    endtask

    task automatic multi_write(input qspi_pkg::qspi_lanes_e lanes);
        int         e0;
        int         w;
        logic [7:0] pl;
        e0 = n_err;
        w  = lane_width(lanes);
        draw_bits(8, pl);
        set_cfg(2'd3, 4'd3, 1'b0);
        arm_slave(8'h00, w);
        send_req(make_req(1'b0, 1'b0, lanes, pl));
        wait_idle();
        check_byte("slave lane byte", seen, pl);
        check_byte("dq_en seen", {4'h0, en_seen}, (w == 2) ? 8'h03 : 8'h0f);
        check_byte("sck periods", 8'(n_rise), 8'(8 / w));
        report_test($sformatf("write on %0d lanes", w), e0);
    endtask

    task automatic dummy_clocks();
        int         e0;
        int         r0;
        logic [7:0] n;
        e0 = n_err;
        r0 = rsp_cnt;
        draw_bits(4, n);
        set_cfg(2'd0, 4'd3, 1'b1);
        arm_slave(8'h00, 1);
        send_req(make_req(1'b0, 1'b1, qspi_pkg::LANES_SINGLE, n));
        wait_idle();
        check_byte("sck periods", 8'(n_rise), n + 8'd1);
        check_byte("dq_en seen", {4'h0, en_seen}, 8'h00);
        check_byte("responses", 8'(rsp_cnt - r0), 8'd0);
        report_test($sformatf("dummy count %0d", n), e0);
    endtask

    task automatic back_pressure();
        int         e0;
        int         r0;
        logic [7:0] rp;
        logic [7:0] pl;
        e0 = n_err;
        r0 = rsp_cnt;
        draw_bits(8, rp);
        draw_bits(8, pl);
        set_cfg(2'd0, 4'd4, 1'b0);
        i_rsp_rdy <= 1'b0;
        arm_slave(rp, 1);
        send_req(make_req(1'b1, 1'b0, qspi_pkg::LANES_SINGLE, 8'h00));
        wait_idle();
        check_byte("sck half period min", 8'(gap_min), 8'd4);
        check_byte("sck half period max", 8'(gap_max), 8'd4);
        arm_slave(8'h00, 1);
        i_req     <= make_req(1'b0, 1'b0, qspi_pkg::LANES_SINGLE, pl);
        i_req_vld <= 1'b1;
        repeat (8) begin
            @(posedge clk);
            check_bit("o_rsp_vld", o_rsp_vld, 1'b1);
            check_bit("o_req_rdy", o_req_rdy, 1'b0);
            check_bit("o_busy", o_busy, 1'b0);
        end
        i_rsp_rdy <= 1'b1;
        do @(posedge clk); while (!o_req_rdy);
        i_req_vld <= 1'b0;
        wait_idle();
        check_byte("responses", 8'(rsp_cnt - r0), 8'd1);
        check_byte("o_rsp_dat", rsp_last, rp);
        check_byte("slave mosi byte", seen, pl);
        report_test("response back-pressure", e0);
    endtask

    initial begin
        repeat (10) @(posedge clk);
        i_rst_n <= 1'b1;
        @(posedge clk);
        check_bit("o_req_rdy after reset", o_req_rdy, 1'b0);
        for (int m = 0; m < 4; m++) begin
            single_write_mode(2'(m));
        end
        duplex_write(1'b1);
        duplex_write(1'b0);
        multi_read(qspi_pkg::LANES_DUAL);
        multi_read(qspi_pkg::LANES_QUAD);
        multi_write(qspi_pkg::LANES_DUAL);
        multi_write(qspi_pkg::LANES_QUAD);
        dummy_clocks();
        back_pressure();
        $display("tests %0d, failed %0d, checks %0d, errors %0d", n_test, n_bad, n_chk, n_err);
        if (n_err == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- files.f
qspi_pkg.sv
qspi_sck_gen.sv
qspi_seq.sv
qspi_shifter.sv
qspi_top.sv
tb_qspi.sv

//--- run.sh
#!/bin/sh
# build and run the qspi testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_qspi \
    -o tb_qspi_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_qspi_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1
